//--- Makefile
VERILATOR  ?= verilator
TOP        ?= fetch_tb
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl #(
    parameter fetch_pkg::addr_t RESET_PC = 32'haaaaa000
) (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    redirect_i,
    input  fetch_pkg::addr_t        redirect_pc_i,

    input  logic                    fill_done_i,
    input  mem_pkg::line_t          fill_line_i,
    input  logic                    queue_full_i,

    output logic                    fill_req_o,
    output fetch_pkg::addr_t        fill_addr_o,
    output logic                    push_o,
    output fetch_pkg::fetch_entry_t push_entry_o
);
    import mem_pkg::*;
    import fetch_pkg::*;

    localparam int ADDR_W = $bits(addr_t);
    localparam int TAG_W  = ADDR_W - LINE_OFFSET_W;
    localparam int SEL_W  = $clog2(WORDS_PER_LINE);

    addr_t  pc;
    order_t order;

    // one-line instruction buffer
    inst_t [WORDS_PER_LINE-1:0] buf_words;
    logic  [TAG_W-1:0]          buf_tag;
    logic                       buf_valid;

    logic             fill_pending;
    logic             fill_stale;
    logic             hit;
    logic [SEL_W-1:0] word_sel;

    assign hit      = buf_valid && (pc[ADDR_W-1:LINE_OFFSET_W] == buf_tag);
    assign word_sel = pc[LINE_OFFSET_W-1:2];

    // no push in a redirect cycle, the queue flushes anyway
    assign push_o = hit && !queue_full_i && !redirect_i;

    always_comb begin
        push_entry_o.order = order;
        push_entry_o.pc    = pc;
        push_entry_o.inst  = buf_words[word_sel];
    end

    // line_fill is idle whenever nothing is pending
    assign fill_req_o  = !hit && !fill_pending && !redirect_i;
    assign fill_addr_o = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc           <= RESET_PC;
            order        <= '0;
            buf_valid    <= 1'b0;
            fill_pending <= 1'b0;
            fill_stale   <= 1'b0;
        end else begin
            if (redirect_i) begin
                pc <= redirect_pc_i;
            end else if (push_o) begin
                pc    <= pc + addr_t'(4);
                order <= order + order_t'(1);
            end

            if (fill_req_o) begin
                fill_pending <= 1'b1;
            end else if (fill_done_i) begin
                fill_pending <= 1'b0;
            end

            // line in flight belongs to the old path
            if (redirect_i && fill_pending && !fill_done_i) begin
                fill_stale <= 1'b1;
            end else if (fill_done_i) begin
                fill_stale <= 1'b0;
            end

            if (fill_done_i && !fill_stale) begin
                buf_valid <= 1'b1;
            end
        end
    end

    // pc has not moved since the request unless the fill is stale
    always_ff @(posedge clk) begin
        if (fill_done_i && !fill_stale) begin
            buf_words <= fill_line_i;
            buf_tag   <= pc[ADDR_W-1:LINE_OFFSET_W];
        end
    end

endmodule

//--- hw/fetch_pkg.sv
package fetch_pkg;

    // byte address
    typedef logic [31:0] addr_t;

    // one RV32I instruction
    typedef logic [31:0] inst_t;

    // fetch sequence number
    typedef logic [63:0] order_t;

    localparam int WORDS_PER_LINE = 8;

    // queue payload, order in the top bits
    typedef struct packed {
        order_t order;
        addr_t  pc;
        inst_t  inst;
    } fetch_entry_t;

endpackage

//--- hw/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    flush_i,
    input  logic                    push_i,
    input  fetch_pkg::fetch_entry_t push_entry_i,
    input  logic                    deq_i,

    output logic                    full_o,
    output logic                    empty_o,
    output fetch_pkg::fetch_entry_t head_o
);
    import fetch_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    fetch_entry_t entries [QUEUE_DEPTH];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full_o  = (count == CNT_W'(QUEUE_DEPTH));
    assign empty_o = (count == '0);

    assign do_push = push_i && !full_o && !flush_i;
    assign do_pop  = deq_i && !empty_o && !flush_i;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // pointers wrap on their own, depth is a power of two
            if (do_push) begin
                tail <= tail + 1'b1;
            end
            if (do_pop) begin
                head <= head + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[tail] <= push_entry_i;
        end
    end

    assign head_o = entries[head];

endmodule

//--- hw/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
    parameter fetch_pkg::addr_t RESET_PC    = 32'haaaaa000,
    parameter int               QUEUE_DEPTH = 8
) (
    input  logic              clk,
    input  logic              rst,

    output fetch_pkg::addr_t  bmem_addr_o,
    output logic              bmem_read_o,
    input  logic              bmem_ready_i,
    input  mem_pkg::beat_t    bmem_rdata_i,
    input  logic              bmem_rvalid_i,

    input  logic              redirect_i,
    input  fetch_pkg::addr_t  redirect_pc_i,

    input  logic              deq_i,
    output logic              empty_o,
    output fetch_pkg::inst_t  inst_o,
    output fetch_pkg::addr_t  pc_o,
    output fetch_pkg::order_t order_o
);
    import mem_pkg::*;
    import fetch_pkg::*;

    logic         fill_req;
    addr_t        fill_addr;
    logic         fill_done;
    line_t        fill_line;
    logic         push;
    fetch_entry_t push_entry;
    logic         full;
    fetch_entry_t head;

    line_fill u_line_fill (
        .clk           (clk),
        .rst           (rst),
        .fill_req_i    (fill_req),
        .fill_addr_i   (fill_addr),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .fill_done_o   (fill_done),
        .fill_line_o   (fill_line)
    );

    fetch_ctrl #(
        .RESET_PC (RESET_PC)
    ) u_fetch_ctrl (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .fill_done_i   (fill_done),
        .fill_line_i   (fill_line),
        .queue_full_i  (full),
        .fill_req_o    (fill_req),
        .fill_addr_o   (fill_addr),
        .push_o        (push),
        .push_entry_o  (push_entry)
    );

    // redirect doubles as the queue flush
    fetch_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_fetch_queue (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (redirect_i),
        .push_i       (push),
        .push_entry_i (push_entry),
        .deq_i        (deq_i),
        .full_o       (full),
        .empty_o      (empty_o),
        .head_o       (head)
    );

    assign inst_o  = head.inst;
    assign pc_o    = head.pc;
    assign order_o = head.order;

endmodule

//--- hw/line_fill.sv
`timescale 1ns/1ps

module line_fill (
    input  logic             clk,
    input  logic             rst,

    input  logic             fill_req_i,
    input  fetch_pkg::addr_t fill_addr_i,

    input  logic             bmem_ready_i,
    input  mem_pkg::beat_t   bmem_rdata_i,
    input  logic             bmem_rvalid_i,
    output fetch_pkg::addr_t bmem_addr_o,
    output logic             bmem_read_o,

    output logic             fill_done_o,
    output mem_pkg::line_t   fill_line_o
);
    import mem_pkg::*;
    import fetch_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        COLLECT
    } state_t;

    state_t    state;
    beat_cnt_t beat_cnt;
    addr_t     line_addr;
    line_t     line_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            beat_cnt    <= '0;
            fill_done_o <= 1'b0;
        end else begin
            fill_done_o <= 1'b0;
            case (state)
                IDLE: begin
                    if (fill_req_i) begin
                        state <= REQ;
                    end
                end
                REQ: begin
                    // read accepted this cycle
                    if (bmem_ready_i) begin
                        state    <= COLLECT;
                        beat_cnt <= '0;
                    end
                end
                COLLECT: begin
                    if (bmem_rvalid_i) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (beat_cnt == beat_cnt_t'(BEATS_PER_LINE - 1)) begin
                            state       <= IDLE;
                            fill_done_o <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && fill_req_i) begin
            line_addr <= {fill_addr_i[$bits(addr_t)-1:LINE_OFFSET_W], {LINE_OFFSET_W{1'b0}}};
        end
        // beat 0 ends up in the low bits
        if (state == COLLECT && bmem_rvalid_i) begin
            line_q <= {bmem_rdata_i, line_q[LINE_W-1:BEAT_W]};
        end
    end

    assign bmem_read_o = (state == REQ);
    assign bmem_addr_o = line_addr;
    assign fill_line_o = line_q;

endmodule

//--- hw/mem_pkg.sv
package mem_pkg;

    // burst memory side
    localparam int BEAT_W = 64;

    typedef logic [BEAT_W-1:0] beat_t;

    // one line is four beats
    localparam int BEATS_PER_LINE = 4;

    localparam int LINE_W = BEAT_W * BEATS_PER_LINE;

    typedef logic [LINE_W-1:0] line_t;

    // byte offset inside a 32-byte line
    localparam int LINE_OFFSET_W = $clog2(LINE_W / 8);

    typedef logic [$clog2(BEATS_PER_LINE)-1:0] beat_cnt_t;

endpackage

//--- project.f
hw/mem_pkg.sv
hw/fetch_pkg.sv
hw/line_fill.sv
hw/fetch_ctrl.sv
hw/fetch_queue.sv
hw/fetch_top.sv
tb/fetch_sva.sv
tb/fetch_tb.sv

//--- tb/fetch_sva.sv
`timescale 1ns/1ps

module fetch_sva (
    input logic             clk,
    input logic             rst,
    input fetch_pkg::addr_t bmem_addr_i,
    input logic             bmem_read_i,
    input logic             bmem_ready_i,
    input logic             empty_i
);
    import mem_pkg::*;

    // burst reads start on a line boundary
    read_aligned: assert property (@(posedge clk) disable iff (rst)
        bmem_read_i |-> bmem_addr_i[LINE_OFFSET_W-1:0] == '0)
        else $error("burst read address %h is not line aligned", bmem_addr_i);

    read_held: assert property (@(posedge clk) disable iff (rst)
        bmem_read_i && !bmem_ready_i |=> bmem_read_i)
        else $error("read request dropped before memory accepted it");

    empty_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> empty_i)
        else $error("instruction queue not empty after reset");

endmodule

bind fetch_top fetch_sva u_fetch_sva (
    .clk          (clk),
    .rst          (rst),
    .bmem_addr_i  (bmem_addr_o),
    .bmem_read_i  (bmem_read_o),
    .bmem_ready_i (bmem_ready_i),
    .empty_i      (empty_o)
);

//--- tb/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;
    import mem_pkg::*;
    import fetch_pkg::*;

    localparam addr_t RESET_PC    = 32'haaaaa000;
    localparam int    QUEUE_DEPTH = 8;
    localparam int    MAX_CYCLES  = 4000;

    logic   clk           = 1'b0;
    logic   rst;
    addr_t  bmem_addr_o;
    logic   bmem_read_o;
    logic   bmem_ready_i  = 1'b0;
    beat_t  bmem_rdata_i  = '0;
    logic   bmem_rvalid_i = 1'b0;
    logic   redirect_i;
    addr_t  redirect_pc_i;
    logic   deq_i;
    logic   empty_o;
    inst_t  inst_o;
    addr_t  pc_o;
    order_t order_o;

    logic [31:0] rnd        = 32'h4d4b;
    int          beats_left = 0;
    addr_t       mem_addr   = '0;
    logic        stall_en   = 1'b0;
    logic        timed_out  = 1'b0;
    int          cycles     = 0;
    int          err_inst;
    int          err_pc;
    int          err_order;
    int          err_other;
    addr_t       next_pc;
    order_t      last_order;
    logic        flushed;

    fetch_top #(
        .RESET_PC    (RESET_PC),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) dut_i (.*);

    initial forever #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // word content of the memory model
    function automatic inst_t mem_word(input addr_t a);
        return a ^ 32'h5a5a5a5a;
    endfunction

    // burst memory, four beats per accepted read
    always @(negedge clk) begin
        rnd = xorshift(rnd);
        if (rst) begin
            beats_left    = 0;
            bmem_ready_i  = 1'b0;
            bmem_rvalid_i = 1'b0;
        end else begin
            bmem_rvalid_i = 1'b0;
            if (beats_left > 0 && !(stall_en && rnd[1:0] == 2'b00)) begin
                bmem_rdata_i  = {mem_word(mem_addr + 32'd4), mem_word(mem_addr)};
                bmem_rvalid_i = 1'b1;
                mem_addr      = mem_addr + 32'd8;
                beats_left    = beats_left - 1;
            end
            bmem_ready_i = !(stall_en && rnd[3:2] == 2'b00);
            // accepted at the coming rising edge
            if (bmem_read_o && bmem_ready_i) begin
                mem_addr   = bmem_addr_o;
                beats_left = BEATS_PER_LINE;
            end
        end
    end

    task automatic check_inst(input inst_t exp, input inst_t act);
        if (act !== exp) begin
            $display("FAIL inst_o expected %h got %h", exp, act);
            err_inst++;
        end
    endtask

    task automatic check_pc(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h got %h", name, exp, act);
            err_pc++;
        end
    endtask

    task automatic check_order(input order_t exp, input order_t act);
        if (act !== exp) begin
            $display("FAIL order_o expected %h got %h", exp, act);
            err_order++;
        end
    endtask

    task automatic pop_and_check();
        @(negedge clk);
        while (empty_o) @(negedge clk);
        check_pc("pc_o", next_pc, pc_o);
        check_inst(mem_word(next_pc), inst_o);
        if (flushed) begin
            if (order_o <= last_order) begin
                $display("order did not move past %0d after a redirect", last_order);
                err_other++;
            end
        end else begin
            check_order(last_order + order_t'(1), order_o);
        end
        last_order = order_o;
        flushed    = 1'b0;
        next_pc    = next_pc + 32'd4;
        deq_i      = 1'b1;
        @(negedge clk);
        deq_i = 1'b0;
    endtask

    task automatic redirect_to(input addr_t target);
        redirect_i    = 1'b1;
        redirect_pc_i = target;
        @(negedge clk);
        redirect_i = 1'b0;
        next_pc    = target;
        flushed    = 1'b1;
    endtask

    task automatic fetch_sequential(input int n);
        repeat (n) pop_and_check();
    endtask

    task automatic hold_backpressure();
        int low_cycles;
        low_cycles = 0;
        while (low_cycles < 40) begin
            @(negedge clk);
            low_cycles = empty_o ? 0 : low_cycles + 1;
        end
        // full queue, so fetch stops one queue ahead of the head
        check_pc("fetch pc", next_pc + 32'(4 * QUEUE_DEPTH), dut_i.u_fetch_ctrl.pc);
        repeat (QUEUE_DEPTH) pop_and_check();
    endtask

    task automatic redirect_paths(input addr_t far_a, input addr_t far_b);
        pop_and_check();
        redirect_to({dut_i.u_fetch_ctrl.pc[31:LINE_OFFSET_W], 5'h0c});
        fetch_sequential(10);
        redirect_to(far_a);
        while (!bmem_read_o) @(negedge clk);
        // line for far_a still in flight
        redirect_to(far_b);
        fetch_sequential(12);
    endtask

    task automatic finish_run();
        $display("errors: inst=%0d pc=%0d order=%0d other=%0d",
                 err_inst, err_pc, err_order, err_other + int'(timed_out));
        if (!timed_out && err_inst + err_pc + err_order + err_other == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the tests did not finish", MAX_CYCLES);
        timed_out = 1'b1;
        finish_run();
    end

    initial begin
        rst           = 1'b1;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        deq_i         = 1'b0;
        err_inst      = 0;
        err_pc        = 0;
        err_order     = 0;
        err_other     = 0;
        next_pc       = RESET_PC;
        last_order    = '1;
        flushed       = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        fetch_sequential(20);
        hold_backpressure();
        redirect_paths(32'h00001004, 32'h12345678);
        stall_en = 1'b1;
        fetch_sequential(20);
        redirect_paths(32'h00002010, 32'h0badc0d8);
        finish_run();
    end

endmodule
